/* common/geometryPkg.sv */
// Playfield geometry
package geometryPkg;

    // screen coordinate
    typedef logic [9:0] coordT;

    // signed coordinate for box arithmetic near the screen edges
    typedef logic signed [11:0] offsetT;

    typedef struct packed {
        coordT x;
        coordT y;
    } coordPairT;

    typedef struct packed {
        coordT x;
        coordT y;
        logic  facingLeft;
        logic  attack;
    } playerStateT;

    localparam int MaxPersons = 8;

    // player box half sizes and fist distance from its centre
    localparam coordT PlayerHalfW = 10'd14;
    localparam coordT PlayerHalfH = 10'd21;
    localparam coordT AttackReach = 10'd14;

    // live body half sizes, by bystander index
    localparam coordT PersonHalfW [MaxPersons] =
        '{10'd10, 10'd8, 10'd11, 10'd6, 10'd20, 10'd13, 10'd13, 10'd10};
    localparam coordT PersonHalfH [MaxPersons] =
        '{10'd22, 10'd22, 10'd23, 10'd16, 10'd24, 10'd24, 10'd17, 10'd22};

    // corpses lie flat, so mostly wide and low
    localparam coordT CorpseHalfW [MaxPersons] =
        '{10'd30, 10'd37, 10'd22, 10'd21, 10'd20, 10'd29, 10'd13, 10'd30};
    localparam coordT CorpseHalfH [MaxPersons] =
        '{10'd5, 10'd9, 10'd5, 10'd6, 10'd20, 10'd5, 10'd17, 10'd5};

    // box centred on centre, both ends inclusive
    function automatic logic inBox(input offsetT px, input offsetT py,
                                   input coordPairT centre,
                                   input coordT halfW, input coordT halfH);
        offsetT cx;
        offsetT cy;
        offsetT hw;
        offsetT hh;
        cx = {2'b00, centre.x};
        cy = {2'b00, centre.y};
        hw = {2'b00, halfW};
        hh = {2'b00, halfH};
        return (px >= cx - hw) && (px <= cx + hw) && (py >= cy - hh) && (py <= cy + hh);
    endfunction

endpackage

/* common/videoPkg.sv */
// Pixel colours and screen modes
package videoPkg;

    typedef logic [23:0] rgbT;

    // player poses
    localparam rgbT PoseRightColor   = 24'hE0B040;
    localparam rgbT PoseLeftColor    = 24'hC09030;
    localparam rgbT AttackRightColor = 24'hF04020;
    localparam rgbT AttackLeftColor  = 24'hC03018;

    // bystanders
    localparam rgbT PersonColor = 24'h3070D0;
    localparam rgbT CorpseColor = 24'h802020;

    // full screen backgrounds
    localparam rgbT StartColor = 24'h101040;
    localparam rgbT LostColor  = 24'h666666;

    typedef enum logic [1:0] {
        modePlay  = 2'd0,
        modeStart = 2'd1,
        modeLost  = 2'd2,
        modeIdle  = 2'd3
    } screenModeT;

    // what lies under one pixel, one cycle after sampling
    typedef struct packed {
        screenModeT mode;
        logic       playerOn;
        logic       facingLeft;
        logic       attack;
    } pixelHitT;

endpackage

/* killTracker/killTracker.sv */
// Bystander kill tracking
`timescale 1ns/1ns

module killTracker #(
    parameter int NumPersons = 4
) (
    input  logic                                   Clk,
    input  logic                                   arstN,
    input  geometryPkg::playerStateT               player,
    input  geometryPkg::coordPairT [NumPersons-1:0] persons,
    input  logic [NumPersons-1:0]                  corpseRemoved,
    output logic [NumPersons-1:0]                  killed,
    output logic [NumPersons-1:0]                  corpseShown,
    output geometryPkg::coordPairT                 deathPos
);

    geometryPkg::offsetT   fistX;
    geometryPkg::offsetT   fistY;
    logic [NumPersons-1:0] fistHit;

    // fist sits level with the centre, on the facing side
    always_comb
    begin
        fistY = {2'b00, player.y};
        if (player.facingLeft)
            fistX = {2'b00, player.x} - {2'b00, geometryPkg::AttackReach};
        else
            fistX = {2'b00, player.x} + {2'b00, geometryPkg::AttackReach};
    end

    for (genvar i = 0; i < NumPersons; i++)
    begin : gFist
        assign fistHit[i] = player.attack && geometryPkg::inBox(fistX, fistY, persons[i],
            geometryPkg::PersonHalfW[i], geometryPkg::PersonHalfH[i]);
    end

    // sticky until reset
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            killed <= '0;
        else
            killed <= killed | fistHit;
    end

    assign corpseShown = killed & ~corpseRemoved;

    // lowest index wins, so scan downwards and let later writes override
    always_comb
    begin
        deathPos = '0;
        for (int i = NumPersons - 1; i >= 0; i--)
        begin
            if (corpseShown[i])
                deathPos = persons[i];
        end
    end

    killedSticky: assert property (@(posedge Clk) disable iff (!arstN)
        ($past(killed) & ~killed) == '0)
        else $error("Error killed fell from %h to %h", $past(killed), killed);

    deathPosIdle: assert property (@(posedge Clk) disable iff (!arstN)
        (corpseShown == '0) |-> (deathPos == '0))
        else $error("Error deathPos %h with no corpse shown", deathPos);

endmodule

/* source/sceneHitTest.sv */
// Per-pixel object hit test
`timescale 1ns/1ns

module sceneHitTest #(
    parameter int NumPersons = 4
) (
    input  logic                                   Clk,
    input  logic                                   arstN,
    input  geometryPkg::coordT                     drawX,
    input  geometryPkg::coordT                     drawY,
    input  geometryPkg::playerStateT               player,
    input  geometryPkg::coordPairT [NumPersons-1:0] persons,
    input  logic [NumPersons-1:0]                  killed,
    input  logic [NumPersons-1:0]                  corpseShown,
    input  logic                                   gameStart,
    input  logic                                   lost,
    output videoPkg::pixelHitT                     hit,
    output logic [NumPersons-1:0]                  aliveHit,
    output logic [NumPersons-1:0]                  corpseHit
);

    videoPkg::screenModeT   mode;
    logic                   playing;
    geometryPkg::offsetT    px;
    geometryPkg::offsetT    py;
    geometryPkg::coordPairT playerPos;
    logic                   playerOn;
    logic [NumPersons-1:0]  aliveOn;
    logic [NumPersons-1:0]  corpseOn;

    always_comb
    begin
        case ({gameStart, lost})
            2'b10:   mode = videoPkg::modeStart;
            2'b01:   mode = videoPkg::modeLost;
            2'b11:   mode = videoPkg::modeIdle;
            default: mode = videoPkg::modePlay;
        endcase
    end

    // objects are drawn only during play
    assign playing = (mode == videoPkg::modePlay);

    assign px = {2'b00, drawX};
    assign py = {2'b00, drawY};
    assign playerPos.x = player.x;
    assign playerPos.y = player.y;

    assign playerOn = playing && geometryPkg::inBox(px, py, playerPos,
        geometryPkg::PlayerHalfW, geometryPkg::PlayerHalfH);

    for (genvar i = 0; i < NumPersons; i++)
    begin : gPerson
        assign aliveOn[i] = playing && !killed[i] && geometryPkg::inBox(px, py, persons[i],
            geometryPkg::PersonHalfW[i], geometryPkg::PersonHalfH[i]);
        // corpse box replaces the body once killed, until removed
        assign corpseOn[i] = playing && corpseShown[i] && geometryPkg::inBox(px, py, persons[i],
            geometryPkg::CorpseHalfW[i], geometryPkg::CorpseHalfH[i]);
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hit       <= '0;
            aliveHit  <= '0;
            corpseHit <= '0;
        end
        else
        begin
            hit.mode       <= mode;
            hit.playerOn   <= playerOn;
            hit.facingLeft <= player.facingLeft;
            hit.attack     <= player.attack;
            aliveHit       <= aliveOn;
            corpseHit      <= corpseOn;
        end
    end

    // a bystander is either standing or lying, never both
    bodyOrCorpse: assert property (@(posedge Clk) disable iff (!arstN)
        (aliveHit & corpseHit) == '0)
        else $error("Error aliveHit %h corpseHit %h overlap", aliveHit, corpseHit);

endmodule

/* compositor/layerCompositor.sv */
// Layer priority and RGB output
`timescale 1ns/1ns

module layerCompositor #(
    parameter int NumPersons = 4
) (
    input  logic                  Clk,
    input  logic                  arstN,
    input  videoPkg::pixelHitT    hit,
    input  logic [NumPersons-1:0] aliveHit,
    input  logic [NumPersons-1:0] corpseHit,
    input  videoPkg::rgbT         backgroundRgb,
    output videoPkg::rgbT         vgaRgb
);

    videoPkg::rgbT modeRgb;
    videoPkg::rgbT poseRgb;
    videoPkg::rgbT pixelRgb;

    // idle shares the playfield background
    always_comb
    begin
        case (hit.mode)
            videoPkg::modeStart: modeRgb = videoPkg::StartColor;
            videoPkg::modeLost:  modeRgb = videoPkg::LostColor;
            default:             modeRgb = backgroundRgb;
        endcase
    end

    always_comb
    begin
        case ({hit.facingLeft, hit.attack})
            2'b00:   poseRgb = videoPkg::PoseRightColor;
            2'b10:   poseRgb = videoPkg::PoseLeftColor;
            2'b01:   poseRgb = videoPkg::AttackRightColor;
            default: poseRgb = videoPkg::AttackLeftColor;
        endcase
    end

    // background, then bystanders, then the player on top
    always_comb
    begin
        pixelRgb = modeRgb;
        for (int i = NumPersons - 1; i >= 0; i--)
        begin
            if (aliveHit[i])
                pixelRgb = videoPkg::PersonColor;
            else if (corpseHit[i])
                pixelRgb = videoPkg::CorpseColor;
        end
        if (hit.playerOn)
            pixelRgb = poseRgb;
    end

    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
            vgaRgb <= '0;
        else
            vgaRgb <= pixelRgb;
    end

    // lost screen hides every object, so it is solid grey
    lostShowsGrey: assert property (@(posedge Clk) disable iff (!arstN)
        (hit.mode == videoPkg::modeLost) |=> (vgaRgb == videoPkg::LostColor))
        else $error("Error vgaRgb %h in lost mode, expected %h",
                    vgaRgb, videoPkg::LostColor);

endmodule

/* source/colorMapper.sv */
// Pixel colour top level
`timescale 1ns/1ns

module colorMapper #(
    parameter int NumPersons = 4
) (
    input  logic                                   Clk,
    input  logic                                   arstN,
    input  geometryPkg::coordT                     drawX,
    input  geometryPkg::coordT                     drawY,
    input  geometryPkg::playerStateT               player,
    input  geometryPkg::coordPairT [NumPersons-1:0] persons,
    input  logic [NumPersons-1:0]                  corpseRemoved,
    input  logic                                   gameStart,
    input  logic                                   lost,
    input  videoPkg::rgbT                          backgroundRgb,
    output videoPkg::rgbT                          vgaRgb,
    output geometryPkg::coordPairT                 deathPos,
    output logic [NumPersons-1:0]                  killed
);

    logic [NumPersons-1:0] corpseShown;
    logic [NumPersons-1:0] aliveHit;
    logic [NumPersons-1:0] corpseHit;
    videoPkg::pixelHitT    hit;

    // size tables only cover MaxPersons entries
    if (NumPersons < 1 || NumPersons > geometryPkg::MaxPersons)
    begin : gBadCount
        $error("NumPersons %0d out of range", NumPersons);
    end

    killTracker #(
        .NumPersons(NumPersons)
    ) killTrackerInst (
        .Clk          (Clk),
        .arstN        (arstN),
        .player       (player),
        .persons      (persons),
        .corpseRemoved(corpseRemoved),
        .killed       (killed),
        .corpseShown  (corpseShown),
        .deathPos     (deathPos)
    );

    sceneHitTest #(
        .NumPersons(NumPersons)
    ) sceneHitTestInst (
        .Clk        (Clk),
        .arstN      (arstN),
        .drawX      (drawX),
        .drawY      (drawY),
        .player     (player),
        .persons    (persons),
        .killed     (killed),
        .corpseShown(corpseShown),
        .gameStart  (gameStart),
        .lost       (lost),
        .hit        (hit),
        .aliveHit   (aliveHit),
        .corpseHit  (corpseHit)
    );

    layerCompositor #(
        .NumPersons(NumPersons)
    ) layerCompositorInst (
        .Clk          (Clk),
        .arstN        (arstN),
        .hit          (hit),
        .aliveHit     (aliveHit),
        .corpseHit    (corpseHit),
        .backgroundRgb(backgroundRgb),
        .vgaRgb       (vgaRgb)
    );

endmodule

/* dv/colorMapperTb.sv */
// Colour mapper testbench
`timescale 1ns/1ns

module colorMapperTb;

    localparam int NumPersons = 4;
    localparam int DriveDelay = 5;
    // stimulus runs for about 125 cycles
    localparam int TimeoutCycles = 4000;

    logic                                    Clk = 1'b0;
    logic                                    arstN;
    geometryPkg::coordT                      drawX;
    geometryPkg::coordT                      drawY;
    geometryPkg::playerStateT                player;
    geometryPkg::coordPairT [NumPersons-1:0] persons;
    logic [NumPersons-1:0]                   corpseRemoved;
    logic                                    gameStart;
    logic                                    lost;
    videoPkg::rgbT                           backgroundRgb;
    videoPkg::rgbT                           vgaRgb;
    geometryPkg::coordPairT                  deathPos;
    logic [NumPersons-1:0]                   killed;

    logic [NumPersons-1:0]  killedModel;
    videoPkg::rgbT          expRgb;
    logic                   expBg;
    geometryPkg::coordPairT expDeath;
    int sinceReset;
    int cycleCount = 0;
    int colourErrors = 0;
    int killErrors = 0;
    int deathErrors = 0;
    int resetErrors = 0;
    int seed = 32'hefcc_e6d5;

    colorMapper #(
        .NumPersons(NumPersons)
    ) DUT (
        .Clk          (Clk),
        .arstN        (arstN),
        .drawX        (drawX),
        .drawY        (drawY),
        .player       (player),
        .persons      (persons),
        .corpseRemoved(corpseRemoved),
        .gameStart    (gameStart),
        .lost         (lost),
        .backgroundRgb(backgroundRgb),
        .vgaRgb       (vgaRgb),
        .deathPos     (deathPos),
        .killed       (killed)
    );

    always #20 Clk = ~Clk;

    function automatic geometryPkg::coordPairT pointAt(input int x, input int y);
        geometryPkg::coordPairT pos;
        pos.x = geometryPkg::coordT'(x);
        pos.y = geometryPkg::coordT'(y);
        return pos;
    endfunction

    function automatic geometryPkg::playerStateT playerAt(input int x, input int y,
                                                          input logic left,
                                                          input logic attack);
        geometryPkg::playerStateT p;
        p.x = geometryPkg::coordT'(x);
        p.y = geometryPkg::coordT'(y);
        p.facingLeft = left;
        p.attack = attack;
        return p;
    endfunction

    // inclusive box test in plain integers
    function automatic logic coversPoint(input int px, input int py,
                                         input geometryPkg::coordPairT centre,
                                         input geometryPkg::coordT halfW,
                                         input geometryPkg::coordT halfH);
        int cx;
        int cy;
        cx = int'(centre.x);
        cy = int'(centre.y);
        return px >= cx - int'(halfW) && px <= cx + int'(halfW)
            && py >= cy - int'(halfH) && py <= cy + int'(halfH);
    endfunction

    function automatic videoPkg::rgbT poseColour(input logic left, input logic attack);
        if (attack)
            return left ? videoPkg::AttackLeftColor : videoPkg::AttackRightColor;
        else
            return left ? videoPkg::PoseLeftColor : videoPkg::PoseRightColor;
    endfunction

    function automatic logic [NumPersons-1:0] fistLands(
        input geometryPkg::playerStateT p,
        input geometryPkg::coordPairT [NumPersons-1:0] bodies);
        int fx;
        logic [NumPersons-1:0] hits;
        fx = int'(p.x) + (p.facingLeft ? -1 : 1) * int'(geometryPkg::AttackReach);
        for (int i = 0; i < NumPersons; i++)
            hits[i] = p.attack && coversPoint(fx, int'(p.y), bodies[i],
                geometryPkg::PersonHalfW[i], geometryPkg::PersonHalfH[i]);
        return hits;
    endfunction

    // useBg marks pixels that take the playfield background input
    function automatic videoPkg::rgbT expectedColour(
        input geometryPkg::coordT x,
        input geometryPkg::coordT y,
        input geometryPkg::playerStateT p,
        input geometryPkg::coordPairT [NumPersons-1:0] bodies,
        input logic [NumPersons-1:0] dead,
        input logic [NumPersons-1:0] removed,
        input logic start,
        input logic over,
        output logic useBg);
        videoPkg::rgbT colour;
        logic found;
        int px;
        int py;
        px = int'(x);
        py = int'(y);
        colour = '0;
        found = 1'b0;
        useBg = 1'b0;
        if (start != over)
            colour = start ? videoPkg::StartColor : videoPkg::LostColor;
        else if (start)
            useBg = 1'b1;
        else if (coversPoint(px, py, {p.x, p.y}, geometryPkg::PlayerHalfW,
                             geometryPkg::PlayerHalfH))
            colour = poseColour(p.facingLeft, p.attack);
        else
        begin
            for (int i = 0; i < NumPersons; i++)
            begin
                if (!found && !dead[i] && coversPoint(px, py, bodies[i],
                    geometryPkg::PersonHalfW[i], geometryPkg::PersonHalfH[i]))
                begin
                    colour = videoPkg::PersonColor;
                    found = 1'b1;
                end
                else if (!found && dead[i] && !removed[i] && coversPoint(px, py, bodies[i],
                    geometryPkg::CorpseHalfW[i], geometryPkg::CorpseHalfH[i]))
                begin
                    colour = videoPkg::CorpseColor;
                    found = 1'b1;
                end
            end
            useBg = !found;
        end
        return colour;
    endfunction

    function automatic geometryPkg::coordPairT firstCorpse(
        input geometryPkg::coordPairT [NumPersons-1:0] bodies,
        input logic [NumPersons-1:0] shown);
        geometryPkg::coordPairT pos;
        logic found;
        pos = '0;
        found = 1'b0;
        for (int i = 0; i < NumPersons; i++)
        begin
            if (!found && shown[i])
            begin
                pos = bodies[i];
                found = 1'b1;
            end
        end
        return pos;
    endfunction

    always @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            killedModel <= '0;
            sinceReset <= 0;
        end
        else
        begin
            killedModel <= killedModel | fistLands(player, persons);
            if (sinceReset < 3)
                sinceReset <= sinceReset + 1;
        end
    end

    always_comb
    begin
        expRgb = expectedColour(drawX, drawY, player, persons, killedModel, corpseRemoved,
                                gameStart, lost, expBg);
        expDeath = firstCorpse(persons, killedModel & ~corpseRemoved);
    end

    // outputs are sampled on the falling edge, where nothing moves
    resetState: assert property (@(negedge Clk)
        (sinceReset == 0) |-> (vgaRgb == '0 && killed == '0 && deathPos == '0))
        else
        begin
            resetErrors++;
            $display("Error after reset vgaRgb %h killed %h deathPos %h",
                     vgaRgb, killed, deathPos);
        end

    // background input is read one stage later, in the compositor
    colourMatch: assert property (@(negedge Clk) disable iff (!arstN)
        (sinceReset >= 2) |->
            (vgaRgb == ($past(expBg, 2) ? $past(backgroundRgb) : $past(expRgb, 2))))
        else
        begin
            colourErrors++;
            $display("Error vgaRgb got %h expected %h", vgaRgb,
                     $past(expBg, 2) ? $past(backgroundRgb) : $past(expRgb, 2));
        end

    killMatch: assert property (@(negedge Clk) disable iff (!arstN)
        killed == killedModel)
        else
        begin
            killErrors++;
            $display("Error killed got %h expected %h", killed, killedModel);
        end

    deathMatch: assert property (@(negedge Clk) disable iff (!arstN)
        deathPos == expDeath)
        else
        begin
            deathErrors++;
            $display("Error deathPos got %h expected %h", deathPos, expDeath);
        end

    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles)
        begin
            $display("Run stopped by timeout after %0d cycles", cycleCount);
            $display("test failed");
            $finish;
        end
    end

    task automatic nextCycle();
        @(posedge Clk);
        #DriveDelay;
    endtask

    task automatic showPixel(input int x, input int y);
        nextCycle();
        drawX = geometryPkg::coordT'(x);
        drawY = geometryPkg::coordT'(y);
    endtask

    task automatic scatter(input int cx, input int cy, input int count);
        for (int n = 0; n < count; n++)
            showPixel(cx + $random(seed) % 24, cy + $random(seed) % 24);
    endtask

    initial
    begin
        arstN = 1'b0;
        drawX = '0;
        drawY = '0;
        player = playerAt(100, 100, 1'b0, 1'b0);
        persons[0] = pointAt(100, 400);
        persons[1] = pointAt(220, 205);
        persons[2] = pointAt(300, 420);
        persons[3] = pointAt(500, 300);
        corpseRemoved = '0;
        gameStart = 1'b0;
        lost = 1'b0;
        backgroundRgb = 24'h204010;
        repeat (10) nextCycle();
        arstN = 1'b1;

        // screen modes with an empty pixel and the player centre
        for (int m = 0; m < 4; m++)
        begin
            gameStart = m[0];
            lost = m[1];
            showPixel(50, 50);
            showPixel(100, 100);
            scatter(100, 100, 6);
        end
        gameStart = 1'b0;
        lost = 1'b0;
        backgroundRgb = 24'h0C3050;
        showPixel(50, 50);

        // four poses, centre and box edges
        for (int pose = 0; pose < 4; pose++)
        begin
            player = playerAt(100, 100, pose[0], pose[1]);
            showPixel(100, 100);
            showPixel(114, 100);
            showPixel(115, 100);
            showPixel(86, 100);
            showPixel(85, 100);
            showPixel(100, 122);
            scatter(100, 100, 4);
        end

        // right fist lands in bystander 1 only with attack and facing right
        player = playerAt(200, 200, 1'b0, 1'b0);
        showPixel(213, 205);
        repeat (3) showPixel(220, 205);
        showPixel(300, 420);
        player = playerAt(200, 200, 1'b1, 1'b1);
        repeat (3) showPixel(220, 205);
        player = playerAt(200, 200, 1'b0, 1'b1);
        showPixel(220, 205);
        player = playerAt(200, 200, 1'b0, 1'b0);
        repeat (3) showPixel(220, 205);
        showPixel(213, 205);
        scatter(220, 205, 8);

        // left fist into bystander 3, then clear the area
        player = playerAt(514, 300, 1'b1, 1'b1);
        showPixel(500, 300);
        player = playerAt(600, 100, 1'b0, 1'b0);
        repeat (3) showPixel(500, 300);
        showPixel(220, 205);

        // corpse removal moves the reported death position
        corpseRemoved = 4'b0010;
        repeat (3) showPixel(220, 205);
        showPixel(500, 300);
        corpseRemoved = 4'b1010;
        repeat (3) showPixel(500, 300);
        scatter(220, 205, 6);

        repeat (3) nextCycle();
        $display("Errors: colour %0d, killed %0d, deathPos %0d, reset %0d",
                 colourErrors, killErrors, deathErrors, resetErrors);
        if (colourErrors + killErrors + deathErrors + resetErrors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* files.f */
common/geometryPkg.sv
common/videoPkg.sv
killTracker/killTracker.sv
source/sceneHitTest.sv
compositor/layerCompositor.sv
source/colorMapper.sv
dv/colorMapperTb.sv

/* Makefile */
TOP = colorMapperTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module colorMapper
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
